// File: zynq_shell_pkg.sv
package zynq_shell_pkg;

  //////////////////////////////////////////////////
  // host register interface

  localparam int axil_data_width_lp   = 32;
  localparam int csr_addr_width_lp    = 3;

  // write side register indices, index 2 is not kept
  localparam int csr_reset_idx_lp     = 0;
  localparam int csr_tag_idx_lp       = 1;
  localparam int csr_dram_base_idx_lp = 3;
  localparam int csr_rom_addr_idx_lp  = 4;

  // readback indices
  localparam int rd_status_idx_lp     = 0;
  localparam int rd_rom_idx_lp        = 1;

  localparam int reset_depth_lp       = 3;

  //////////////////////////////////////////////////
  // dram addressing

  localparam int dram_addr_width_lp   = 32;
  localparam int cache_id_width_lp    = 4;
  localparam int dram_offset_width_lp = 26;

  //////////////////////////////////////////////////
  // machine description rom

  localparam int rom_els_lp           = 8;
  localparam int rom_addr_width_lp    = 3;

  // word 0 sits at the right end
  localparam logic [rom_els_lp-1:0][axil_data_width_lp-1:0] machine_rom_lp = {
    32'h0400_0000,  // dram bytes per cache
    32'h0000_0010,  // number of caches
    32'h0000_0008,  // cache line words
    32'h0000_0004,  // cache ways
    32'h0000_0040,  // cache sets
    32'h0004_0008,  // tiles y, tiles x
    32'h0001_0001,  // pods y, pods x
    32'h2023_0001   // format version
  };

  typedef struct packed {
    logic [csr_addr_width_lp-1:0]  addr;
    logic [axil_data_width_lp-1:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic                          core_release;
    logic [dram_addr_width_lp-1:0] dram_base;
    logic [rom_addr_width_lp-1:0]  rom_addr;
  } csr_ctrl_t;

  typedef struct packed {
    logic [cache_id_width_lp-1:0]  cache_id;
    logic [dram_addr_width_lp-1:0] offset;
  } dram_req_t;

endpackage

// File: zynq_csr_regs.sv
`timescale 1ns/10ps

module zynq_csr_regs
  (
    input  logic                    aclk_i
  , input  logic                    rst_n_i

  , input  logic                    csr_wr_v_i
  , input  zynq_shell_pkg::csr_wr_t csr_wr_i

  , output zynq_shell_pkg::csr_ctrl_t ctrl_o
  , output logic                    tag_bit_v_o
  , output logic                    tag_bit_o
  );

  import zynq_shell_pkg::*;

  csr_ctrl_t ctrl_r;
  logic      wr_reset;
  logic      wr_tag;
  logic      wr_dram_base;
  logic      wr_rom_addr;

  // index decode
  assign wr_reset     = csr_wr_v_i && (csr_wr_i.addr == csr_addr_width_lp'(csr_reset_idx_lp));
  assign wr_tag       = csr_wr_v_i && (csr_wr_i.addr == csr_addr_width_lp'(csr_tag_idx_lp));
  assign wr_dram_base = csr_wr_v_i
                        && (csr_wr_i.addr == csr_addr_width_lp'(csr_dram_base_idx_lp));
  assign wr_rom_addr  = csr_wr_v_i
                        && (csr_wr_i.addr == csr_addr_width_lp'(csr_rom_addr_idx_lp));

  always_ff @(posedge aclk_i)
  begin
    if (!rst_n_i)
    begin
      ctrl_r <= '0;
    end
    else
    begin
      if (wr_reset)
      begin
        ctrl_r.core_release <= csr_wr_i.data[0];
      end
      if (wr_dram_base)
      begin
        ctrl_r.dram_base <= csr_wr_i.data[dram_addr_width_lp-1:0];
      end
      if (wr_rom_addr)
      begin
        ctrl_r.rom_addr <= csr_wr_i.data[rom_addr_width_lp-1:0];
      end
    end
  end

  assign ctrl_o = ctrl_r;

  // tag register is not kept, each write is a new bit
  assign tag_bit_v_o = wr_tag;
  assign tag_bit_o   = csr_wr_i.data[0];

endmodule

// File: reset_delay_chain.sv
`timescale 1ns/10ps

module reset_delay_chain
  (
    input  logic aclk_i
  , input  logic rst_n_i

  , input  logic release_i
  , output logic core_reset_o
  );

  import zynq_shell_pkg::*;

  logic [reset_depth_lp-1:0] chain_r;

  // every stage comes out of reset asserted
  always_ff @(posedge aclk_i)
  begin
    if (!rst_n_i)
    begin
      chain_r <= '1;
    end
    else
    begin
      chain_r <= {chain_r[reset_depth_lp-2:0], ~release_i};
    end
  end

  assign core_reset_o = chain_r[reset_depth_lp-1];

endmodule

// File: tag_bitbang.sv
`timescale 1ns/10ps

module tag_bitbang
  (
    input  logic aclk_i
  , input  logic rst_n_i

  , input  logic bit_v_i
  , input  logic bit_i

  , output logic tag_clk_o
  , output logic tag_data_o
  , output logic busy_o
  );

  typedef enum logic [1:0] {idle_s, load_s, high_s} bb_state_e;

  bb_state_e state_r;
  logic      pend_bit_r;
  logic      tag_clk_r;
  logic      tag_data_r;

  always_ff @(posedge aclk_i)
  begin
    if (!rst_n_i)
    begin
      state_r    <= idle_s;
      pend_bit_r <= 1'b0;
      tag_clk_r  <= 1'b0;
      tag_data_r <= 1'b0;
    end
    else
    begin
      case (state_r)
        idle_s:
        begin
          // strobes outside idle are dropped
          if (bit_v_i)
          begin
            pend_bit_r <= bit_i;
            state_r    <= load_s;
          end
        end
        load_s:
        begin
          tag_data_r <= pend_bit_r;
          tag_clk_r  <= 1'b1;
          state_r    <= high_s;
        end
        high_s:
        begin
          // data holds until the next bit
          tag_clk_r <= 1'b0;
          state_r   <= idle_s;
        end
        default:
        begin
          state_r <= idle_s;
        end
      endcase
    end
  end

  assign tag_clk_o  = tag_clk_r;
  assign tag_data_o = tag_data_r;
  assign busy_o     = (state_r != idle_s);

endmodule

// File: dram_addr_hash.sv
`timescale 1ns/10ps

module dram_addr_hash
  (
    input  logic                                        aclk_i
  , input  logic                                        rst_n_i

  , input  logic                                        req_v_i
  , input  zynq_shell_pkg::dram_req_t                   req_i
  , input  logic [zynq_shell_pkg::dram_addr_width_lp-1:0] dram_base_i

  , output logic                                        addr_v_o
  , output logic [zynq_shell_pkg::dram_addr_width_lp-1:0] addr_o
  );

  import zynq_shell_pkg::*;

  logic [dram_addr_width_lp-1:0] hash_addr;
  logic [dram_addr_width_lp-1:0] phys_addr;
  logic [dram_addr_width_lp-1:0] addr_r;
  logic                          addr_v_r;

  // cache id right above the kept offset bits
  assign hash_addr = {
    {(dram_addr_width_lp-cache_id_width_lp-dram_offset_width_lp){1'b0}},
    req_i.cache_id,
    req_i.offset[dram_offset_width_lp-1:0]
  };

  // wraps at 2^32
  assign phys_addr = hash_addr + dram_base_i;

  always_ff @(posedge aclk_i)
  begin
    if (!rst_n_i)
    begin
      addr_v_r <= 1'b0;
    end
    else
    begin
      addr_v_r <= req_v_i;
    end
  end

  always_ff @(posedge aclk_i)
  begin
    if (req_v_i)
    begin
      addr_r <= phys_addr;
    end
  end

  assign addr_v_o = addr_v_r;
  assign addr_o   = addr_r;

endmodule

// File: csr_readback.sv
`timescale 1ns/10ps

module csr_readback
  (
    input  logic                                         aclk_i
  , input  logic                                         rst_n_i

  , input  logic                                         rd_v_i
  , input  logic [zynq_shell_pkg::csr_addr_width_lp-1:0] rd_addr_i

  , input  logic [zynq_shell_pkg::rom_addr_width_lp-1:0] rom_addr_i
  , input  logic                                         core_reset_i
  , input  logic                                         tag_busy_i

  , output logic                                         rd_v_o
  , output logic [zynq_shell_pkg::axil_data_width_lp-1:0] rd_data_o
  );

  import zynq_shell_pkg::*;

  logic [axil_data_width_lp-1:0] rom_word;
  logic [axil_data_width_lp-1:0] status_word;
  logic [axil_data_width_lp-1:0] rd_word;
  logic [axil_data_width_lp-1:0] rd_data_r;
  logic                          rd_v_r;

  assign rom_word    = machine_rom_lp[rom_addr_i];
  assign status_word = {{(axil_data_width_lp-2){1'b0}}, tag_busy_i, core_reset_i};

  always_comb
  begin
    rd_word = '0;
    if (rd_addr_i == csr_addr_width_lp'(rd_status_idx_lp))
    begin
      rd_word = status_word;
    end
    else if (rd_addr_i == csr_addr_width_lp'(rd_rom_idx_lp))
    begin
      rd_word = rom_word;
    end
  end

  always_ff @(posedge aclk_i)
  begin
    if (!rst_n_i)
    begin
      rd_v_r <= 1'b0;
    end
    else
    begin
      rd_v_r <= rd_v_i;
    end
  end

  // data only moves on a read
  always_ff @(posedge aclk_i)
  begin
    if (rd_v_i)
    begin
      rd_data_r <= rd_word;
    end
  end

  assign rd_v_o    = rd_v_r;
  assign rd_data_o = rd_data_r;

endmodule

// File: zynq_shell_top.sv
`timescale 1ns/10ps

module zynq_shell_top
  (
    input  logic                                          aclk_i
  , input  logic                                          rst_n_i

  // host register writes and reads
  , input  logic                                          csr_wr_v_i
  , input  zynq_shell_pkg::csr_wr_t                       csr_wr_i
  , input  logic                                          csr_rd_v_i
  , input  logic [zynq_shell_pkg::csr_addr_width_lp-1:0]  csr_rd_addr_i
  , output logic                                          csr_rd_v_o
  , output logic [zynq_shell_pkg::axil_data_width_lp-1:0] csr_rd_data_o

  // dram requests from the caches
  , input  logic                                          aw_req_v_i
  , input  zynq_shell_pkg::dram_req_t                     aw_req_i
  , input  logic                                          ar_req_v_i
  , input  zynq_shell_pkg::dram_req_t                     ar_req_i
  , output logic                                          awaddr_v_o
  , output logic [zynq_shell_pkg::dram_addr_width_lp-1:0] awaddr_o
  , output logic                                          araddr_v_o
  , output logic [zynq_shell_pkg::dram_addr_width_lp-1:0] araddr_o

  // fabric control
  , output logic                                          core_reset_o
  , output logic                                          tag_clk_o
  , output logic                                          tag_data_o
  );

  import zynq_shell_pkg::*;

  csr_ctrl_t ctrl;
  logic      tag_bit_v;
  logic      tag_bit;
  logic      tag_busy;
  logic      core_reset;

  //////////////////////////////////////////////////
  // control registers and their consumers

  zynq_csr_regs u_csr_regs
    (.aclk_i      (aclk_i)
    ,.rst_n_i     (rst_n_i)
    ,.csr_wr_v_i  (csr_wr_v_i)
    ,.csr_wr_i    (csr_wr_i)
    ,.ctrl_o      (ctrl)
    ,.tag_bit_v_o (tag_bit_v)
    ,.tag_bit_o   (tag_bit)
    );

  reset_delay_chain u_reset_chain
    (.aclk_i       (aclk_i)
    ,.rst_n_i      (rst_n_i)
    ,.release_i    (ctrl.core_release)
    ,.core_reset_o (core_reset)
    );

  assign core_reset_o = core_reset;

  tag_bitbang u_tag_bitbang
    (.aclk_i     (aclk_i)
    ,.rst_n_i    (rst_n_i)
    ,.bit_v_i    (tag_bit_v)
    ,.bit_i      (tag_bit)
    ,.tag_clk_o  (tag_clk_o)
    ,.tag_data_o (tag_data_o)
    ,.busy_o     (tag_busy)
    );

  //////////////////////////////////////////////////
  // dram address translation, write and read side

  dram_addr_hash aw_hash_i
    (.aclk_i      (aclk_i)
    ,.rst_n_i     (rst_n_i)
    ,.req_v_i     (aw_req_v_i)
    ,.req_i       (aw_req_i)
    ,.dram_base_i (ctrl.dram_base)
    ,.addr_v_o    (awaddr_v_o)
    ,.addr_o      (awaddr_o)
    );

  dram_addr_hash ar_hash_i
    (.aclk_i      (aclk_i)
    ,.rst_n_i     (rst_n_i)
    ,.req_v_i     (ar_req_v_i)
    ,.req_i       (ar_req_i)
    ,.dram_base_i (ctrl.dram_base)
    ,.addr_v_o    (araddr_v_o)
    ,.addr_o      (araddr_o)
    );

  //////////////////////////////////////////////////
  // status readback

  csr_readback u_readback
    (.aclk_i       (aclk_i)
    ,.rst_n_i      (rst_n_i)
    ,.rd_v_i       (csr_rd_v_i)
    ,.rd_addr_i    (csr_rd_addr_i)
    ,.rom_addr_i   (ctrl.rom_addr)
    ,.core_reset_i (core_reset)
    ,.tag_busy_i   (tag_busy)
    ,.rd_v_o       (csr_rd_v_o)
    ,.rd_data_o    (csr_rd_data_o)
    );

endmodule

// File: zynq_shell_assert.sv
`timescale 1ns/10ps

module zynq_shell_assert
  (
    input logic aclk_i
  , input logic rst_n_i
  , input logic tag_clk_o
  , input logic aw_req_v_i
  , input logic awaddr_v_o
  , input logic ar_req_v_i
  , input logic araddr_v_o
  , input logic csr_rd_v_i
  , input logic csr_rd_v_o
  );

  // tag clock high for one cycle only
  tag_clk_single_a: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
    tag_clk_o |=> !tag_clk_o)
    else $error("tag clock held high for two cycles");

  aw_latency_a: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
    awaddr_v_o == $past(aw_req_v_i))
    else $error("write address valid not one cycle after its request");

  ar_latency_a: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
    araddr_v_o == $past(ar_req_v_i))
    else $error("read address valid not one cycle after its request");

  rd_latency_a: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
    csr_rd_v_o == $past(csr_rd_v_i))
    else $error("readback valid not one cycle after the read strobe");

endmodule

bind zynq_shell_top zynq_shell_assert u_shell_assert (.*);

// File: tb_zynq_shell.sv
`timescale 1ns/10ps

module tb_zynq_shell;

  import zynq_shell_pkg::*;

  typedef struct packed {
    logic [63:0] due;
    logic [31:0] data;
  } expect_t;

  logic                          aclk_i;
  logic                          rst_n_i;
  logic                          csr_wr_v_i;
  csr_wr_t                       csr_wr_i;
  logic                          csr_rd_v_i;
  logic [csr_addr_width_lp-1:0]  csr_rd_addr_i;
  logic                          csr_rd_v_o;
  logic [axil_data_width_lp-1:0] csr_rd_data_o;
  logic                          aw_req_v_i;
  dram_req_t                     aw_req_i;
  logic                          ar_req_v_i;
  dram_req_t                     ar_req_i;
  logic                          awaddr_v_o;
  logic [dram_addr_width_lp-1:0] awaddr_o;
  logic                          araddr_v_o;
  logic [dram_addr_width_lp-1:0] araddr_o;
  logic                          core_reset_o;
  logic                          tag_clk_o;
  logic                          tag_data_o;

  expect_t                       aw_q[$];
  expect_t                       ar_q[$];
  expect_t                       rd_q[$];
  logic                          tag_q[$];
  logic                          exp_core_reset;
  logic [rom_addr_width_lp-1:0]  rom_addr;
  logic [31:0]                   dram_base;

  zynq_shell_top dut_i (.*);

  initial
  begin
    aclk_i = 1'b0;
    forever #10 aclk_i = ~aclk_i;
  end

  //////////////////////////////////////////////////
  // reference model

  function automatic logic [31:0] expected_addr(input logic [31:0] base,
                                                input logic [3:0] cache_id,
                                                input logic [31:0] offset);
    logic [31:0] local_addr;
    local_addr = (32'(cache_id) << dram_offset_width_lp)
                 | (offset & ((32'd1 << dram_offset_width_lp) - 32'd1));
    return local_addr + base;
  endfunction

  function automatic logic [31:0] expected_read(input logic [2:0] idx,
                                                input logic [2:0] rom_a,
                                                input logic core_rst,
                                                input logic busy);
    case (idx)
      3'd0:    return {30'd0, busy, core_rst};
      3'd1:    return machine_rom_lp[rom_a];
      default: return 32'd0;
    endcase
  endfunction

  // chain output moves reset_depth_lp edges after the write edge
  function automatic logic expected_core_reset(input logic rel, input int edges,
                                               input logic prev);
    return (edges >= reset_depth_lp) ? !rel : prev;
  endfunction

  //////////////////////////////////////////////////
  // checking

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check(input string name, input logic [63:0] exp_v, input logic [63:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("** Error %s: expected %0h, actual %0h", name, exp_v, act_v);
      stop_run("value mismatch");
    end
  endtask

  initial
  begin
    logic    tag_clk_q;
    logic    b;
    expect_t e;
    tag_clk_q = 1'b0;
    forever
    begin
      @(negedge aclk_i);
      if (awaddr_v_o)
      begin
        if (aw_q.size() == 0)
          stop_run("write address valid with no request pending");
        else
        begin
          e = aw_q.pop_front();
          check("aw latency", e.due, 64'($time));
          check("aw address", 64'(e.data), 64'(awaddr_o));
        end
      end
      else if (aw_q.size() != 0 && aw_q[0].due <= $time)
        stop_run("write address valid missing");
      if (araddr_v_o)
      begin
        if (ar_q.size() == 0)
          stop_run("read address valid with no request pending");
        else
        begin
          e = ar_q.pop_front();
          check("ar latency", e.due, 64'($time));
          check("ar address", 64'(e.data), 64'(araddr_o));
        end
      end
      else if (ar_q.size() != 0 && ar_q[0].due <= $time)
        stop_run("read address valid missing");
      if (csr_rd_v_o)
      begin
        if (rd_q.size() == 0)
          stop_run("readback valid with no read pending");
        else
        begin
          e = rd_q.pop_front();
          check("readback latency", e.due, 64'($time));
          check("readback data", 64'(e.data), 64'(csr_rd_data_o));
        end
      end
      else if (rd_q.size() != 0 && rd_q[0].due <= $time)
        stop_run("readback valid missing");
      // one pulse per bit on the rising tag clock
      if (tag_clk_o && !tag_clk_q)
      begin
        if (tag_q.size() == 0)
          stop_run("tag clock pulse with no tag bit pending");
        else
        begin
          b = tag_q.pop_front();
          check("tag data", 64'(b), 64'(tag_data_o));
        end
      end
      tag_clk_q = tag_clk_o;
    end
  end

  //////////////////////////////////////////////////
  // stimulus

  task automatic csr_write(input logic [2:0] idx, input logic [31:0] data);
    @(posedge aclk_i);
    csr_wr_v_i    <= 1'b1;
    csr_wr_i.addr <= idx;
    csr_wr_i.data <= data;
    @(posedge aclk_i);
    csr_wr_v_i    <= 1'b0;
  endtask

  task automatic csr_read(input logic [2:0] idx, input logic busy);
    expect_t e;
    @(posedge aclk_i);
    csr_rd_v_i    <= 1'b1;
    csr_rd_addr_i <= idx;
    e.due  = $time + 30;
    e.data = expected_read(idx, rom_addr, exp_core_reset, busy);
    rd_q.push_back(e);
    @(posedge aclk_i);
    csr_rd_v_i    <= 1'b0;
  endtask

  task automatic tag_write(input logic b);
    tag_q.push_back(b);
    csr_write(3'(csr_tag_idx_lp), {31'd0, b});
  endtask

  task automatic reset_follow(input logic rel);
    logic prev;
    prev = exp_core_reset;
    for (int e = 0; e <= reset_depth_lp + 2; e++)
    begin
      if (e > 0)
        @(posedge aclk_i);
      @(negedge aclk_i);
      check("core reset delay", 64'(expected_core_reset(rel, e, prev)), 64'(core_reset_o));
    end
    exp_core_reset = !rel;
  endtask

  task automatic issue_requests(input int cycles);
    dram_req_t req;
    logic      v;
    expect_t   e;
    for (int i = 0; i < cycles; i++)
    begin
      @(posedge aclk_i);
      v            = ($urandom_range(3, 0) != 0);
      req.cache_id = 4'($urandom);
      req.offset   = $urandom;
      aw_req_v_i  <= v;
      aw_req_i    <= req;
      e.due        = $time + 30;
      e.data       = expected_addr(dram_base, req.cache_id, req.offset);
      if (v)
        aw_q.push_back(e);
      v            = ($urandom_range(3, 0) != 0);
      req.cache_id = 4'($urandom);
      req.offset   = $urandom;
      ar_req_v_i  <= v;
      ar_req_i    <= req;
      e.data       = expected_addr(dram_base, req.cache_id, req.offset);
      if (v)
        ar_q.push_back(e);
    end
    @(posedge aclk_i);
    aw_req_v_i <= 1'b0;
    ar_req_v_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while ((aw_q.size() + ar_q.size() + rd_q.size() + tag_q.size()) != 0 && waited < 100)
    begin
      @(posedge aclk_i);
      waited++;
    end
    if ((aw_q.size() + ar_q.size() + rd_q.size() + tag_q.size()) != 0)
      stop_run("timed out waiting for outstanding responses");
    else
      repeat (2) @(posedge aclk_i);
  endtask

  initial
  begin
    logic [31:0] data;
    void'($urandom(32'hbc05_1a99));
    rst_n_i        = 1'b0;
    csr_wr_v_i     = 1'b0;
    csr_wr_i       = '0;
    csr_rd_v_i     = 1'b0;
    csr_rd_addr_i  = '0;
    aw_req_v_i     = 1'b0;
    aw_req_i       = '0;
    ar_req_v_i     = 1'b0;
    ar_req_i       = '0;
    exp_core_reset = 1'b1;
    rom_addr       = '0;
    dram_base      = '0;
    repeat (8) @(posedge aclk_i);
    rst_n_i <= 1'b1;
    @(posedge aclk_i);
    @(negedge aclk_i);

    // state after reset
    check("reset core_reset", 64'd1, 64'(core_reset_o));
    check("reset tag outputs", 64'd0, 64'({tag_clk_o, tag_data_o}));
    check("reset valids", 64'd0, 64'({awaddr_v_o, araddr_v_o, csr_rd_v_o}));
    csr_read(3'(rd_status_idx_lp), 1'b0);
    wait_drain();

    // core reset release and reassert
    csr_write(3'(csr_reset_idx_lp), 32'd1);
    reset_follow(1'b1);
    csr_write(3'(csr_reset_idx_lp), 32'd0);
    reset_follow(1'b0);
    csr_write(3'(csr_reset_idx_lp), 32'd1);
    reset_follow(1'b1);

    // tag stream with three to five cycles between strobes
    for (int i = 0; i < 20; i++)
    begin
      tag_write(1'($urandom));
      repeat (1 + $urandom_range(2, 0)) @(posedge aclk_i);
    end
    wait_drain();

    // address hash under several bases
    for (int r = 0; r < 4; r++)
    begin
      dram_base = $urandom;
      csr_write(3'(csr_dram_base_idx_lp), dram_base);
      issue_requests(16);
    end
    wait_drain();

    // rom and status readback
    for (int i = 0; i < 8; i++)
    begin
      data     = $urandom;
      rom_addr = data[rom_addr_width_lp-1:0];
      csr_write(3'(csr_rom_addr_idx_lp), data);
      csr_read(3'(rd_rom_idx_lp), 1'b0);
    end
    for (int idx = 2; idx < 8; idx++)
      csr_read(3'(idx), 1'b0);
    tag_write(1'($urandom));
    csr_read(3'(rd_status_idx_lp), 1'b1);
    wait_drain();

    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: src.f
zynq_shell_pkg.sv
zynq_csr_regs.sv
reset_delay_chain.sv
tag_bitbang.sv
dram_addr_hash.sv
csr_readback.sv
zynq_shell_top.sv
zynq_shell_assert.sv
tb_zynq_shell.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench, exit status carries the result
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f src.f \
       --top-module tb_zynq_shell -Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb \
  || { echo "simulation did not pass"; exit 1; }
